//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := arm_core_tb
FILELIST  := all.f
OBJDIR    := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the simulation with Verilator"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

//--- all.f
+incdir+common
common/arm_pkg.sv
verilog/if_stage.sv
verilog/id_stage.sv
verilog/ex_stage.sv
verilog/mem_stage.sv
verilog/hazard_unit.sv
verilog/arm_core.sv
sim/arm_core_tb.sv

//--- common/arm_defs.svh
`ifndef ARM_DEFS_SVH
`define ARM_DEFS_SVH

// datapath widths
`define ADDRESS_LEN      32
`define REGISTER_LEN     32
`define REG_ADDRESS_LEN  4
`define INSTR_LEN        32

// memory sizes in words
`define IMEM_DEPTH       64
`define DMEM_DEPTH       64

// data-processing opcodes
`define OP_AND           4'b0000
`define OP_EOR           4'b0001
`define OP_SUB           4'b0010
`define OP_ADD           4'b0100
`define OP_ORR           4'b1100
`define OP_MOV           4'b1101

// instruction class, bits 27:26
`define CLASS_DP         2'b00
`define CLASS_MEM        2'b01
`define CLASS_NOP        2'b11

// always-condition word of the no-op class
`define NOP_INSTR        {4'hE, `CLASS_NOP, 26'd0}

`endif

//--- common/arm_pkg.sv
`include "arm_defs.svh"

package arm_pkg;

	// data-processing view of an instruction word
	typedef struct packed {
		logic [3:0]                  cond;
		logic [1:0]                  cls;
		logic                        imm;
		logic [3:0]                  opcode;
		logic                        s;
		logic [`REG_ADDRESS_LEN-1:0] rn;
		logic [`REG_ADDRESS_LEN-1:0] rd;
		logic [11:0]                 operand2;
	} dp_fields_t;

	// single word transfer view
	typedef struct packed {
		logic [3:0]                  cond;
		logic [1:0]                  cls;
		logic                        i;
		logic                        p;
		logic                        u;
		logic                        b;
		logic                        w;
		logic                        load;
		logic [`REG_ADDRESS_LEN-1:0] rn;
		logic [`REG_ADDRESS_LEN-1:0] rd;
		logic [11:0]                 offset;
	} mem_fields_t;

	typedef union packed {
		dp_fields_t  dp;
		mem_fields_t mem;
	} instr_u;

	// pass selects the address adder for LDR/STR
	typedef enum logic [2:0] {
		alu_and,
		alu_eor,
		alu_sub,
		alu_add,
		alu_orr,
		alu_mov,
		alu_pass
	} alu_cmd_e;

	typedef struct packed {
		logic                        valid;
		logic                        wb_en;
		logic                        mem_read;
		logic                        mem_write;
		alu_cmd_e                    alu_cmd;
		logic [`REGISTER_LEN-1:0]    val_rn;
		logic [`REGISTER_LEN-1:0]    val_op2;
		logic [`REGISTER_LEN-1:0]    val_rm;
		logic [`REG_ADDRESS_LEN-1:0] dest;
	} id_ex_t;

	typedef struct packed {
		logic                        valid;
		logic                        wb_en;
		logic                        mem_read;
		logic                        mem_write;
		logic [`REGISTER_LEN-1:0]    alu_res;
		logic [`REGISTER_LEN-1:0]    val_rm;
		logic [`REG_ADDRESS_LEN-1:0] dest;
	} ex_mem_t;

	// register write, also the retire trace
	typedef struct packed {
		logic                        wb_en;
		logic [`REG_ADDRESS_LEN-1:0] dest;
		logic [`REGISTER_LEN-1:0]    value;
	} wb_t;

	typedef struct packed {
		logic                        wb_en;
		logic [`REG_ADDRESS_LEN-1:0] dest;
	} hazard_src_t;

endpackage

//--- sim/arm_core_tb.sv
`timescale 1ns/1ps
`include "arm_defs.svh"

module arm_core_tb;

	localparam int IMEM_AW = $clog2(`IMEM_DEPTH);
	localparam int DMEM_AW = $clog2(`DMEM_DEPTH);
	localparam int NUM_INSTR = 40;
	localparam int RESET_CYCLES = 10;
	localparam int RETIRE_TIMEOUT = 64;
	// program wraps after the no-op padding, so this stays well short of it
	localparam int QUIET_CYCLES = 12;

	logic                   clk;
	logic                   rst_n;
	logic                   imem_load_en;
	logic [IMEM_AW-1:0]     imem_load_addr;
	logic [`INSTR_LEN-1:0]  imem_load_data;
	arm_pkg::wb_t           wb;

	logic [`INSTR_LEN-1:0]       program_words [0:`IMEM_DEPTH-1];
	logic [`REGISTER_LEN-1:0]    model_regs [0:15];
	logic [`REGISTER_LEN-1:0]    model_mem [0:`DMEM_DEPTH-1];
	logic                        model_written [0:`DMEM_DEPTH-1];
	logic [`REG_ADDRESS_LEN-1:0] exp_dest [$];
	logic [`REGISTER_LEN-1:0]    exp_value [$];

	arm_core u_arm_core (
		.clk(clk), .rst_n(rst_n),
		.imem_load_en(imem_load_en),
		.imem_load_addr(imem_load_addr),
		.imem_load_data(imem_load_data),
		.wb(wb)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ########################################################################
	// reporting
	// ########################################################################

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected)
			abort_run($sformatf("error %s expected %0h actual %0h", name, expected, actual));
	endtask

	task automatic wait_retire(input int idx);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (wb.wb_en !== 1'b1) begin
			if (cycles >= RETIRE_TIMEOUT)
				abort_run($sformatf("no retirement arrived for write %0d within %0d cycles",
					idx, RETIRE_TIMEOUT));
			cycles++;
			@(negedge clk);
		end
	endtask

	// ########################################################################
	// ISA model and program generator
	// ########################################################################

	// mostly r0-r3 so that neighbours depend on each other
	function automatic logic [3:0] pick_reg();
		if ($urandom_range(3, 0) != 0)
			return 4'($urandom_range(3, 0));
		return 4'($urandom_range(15, 0));
	endfunction

	function automatic logic [3:0] pick_opcode();
		case ($urandom_range(5, 0))
			0: return `OP_AND;
			1: return `OP_EOR;
			2: return `OP_SUB;
			3: return `OP_ADD;
			4: return `OP_ORR;
			default: return `OP_MOV;
		endcase
	endfunction

	task automatic record_write(input logic [3:0] rd, input logic [`REGISTER_LEN-1:0] value);
		model_regs[rd] = value;
		exp_dest.push_back(rd);
		exp_value.push_back(value);
	endtask

	task automatic model_step(input arm_pkg::instr_u w);
		logic [`REGISTER_LEN-1:0] op2;
		logic [`REGISTER_LEN-1:0] res;
		logic [`REGISTER_LEN-1:0] addr;
		logic                     known;
		op2 = w.dp.imm ? {{(`REGISTER_LEN-8){1'b0}}, w.dp.operand2[7:0]}
			: model_regs[w.dp.operand2[3:0]];
		addr = model_regs[w.mem.rn] + {{(`REGISTER_LEN-12){1'b0}}, w.mem.offset};
		known = 1'b1;
		res = '0;
		case (w.dp.cls)
			`CLASS_DP: begin
				case (w.dp.opcode)
					`OP_AND: res = model_regs[w.dp.rn] & op2;
					`OP_EOR: res = model_regs[w.dp.rn] ^ op2;
					`OP_SUB: res = model_regs[w.dp.rn] - op2;
					`OP_ADD: res = model_regs[w.dp.rn] + op2;
					`OP_ORR: res = model_regs[w.dp.rn] | op2;
					`OP_MOV: res = op2;
					default: known = 1'b0;
				endcase
				if (known)
					record_write(w.dp.rd, res);
			end
			`CLASS_MEM: begin
				if (w.mem.load) begin
					record_write(w.mem.rd, model_mem[addr[DMEM_AW+1:2]]);
				end else begin
					model_mem[addr[DMEM_AW+1:2]] = model_regs[w.mem.rd];
					model_written[addr[DMEM_AW+1:2]] = 1'b1;
				end
			end
			default: ;
		endcase
	endtask

	task automatic build_program();
		arm_pkg::instr_u          w;
		int                       kind;
		logic                     prev_store;
		logic [3:0]               prev_rn;
		logic [11:0]              prev_offset;
		logic [`REGISTER_LEN-1:0] addr;
		prev_store = 1'b0;
		prev_rn = '0;
		prev_offset = '0;
		for (int i = 0; i < 16; i++)
			model_regs[i] = '0;
		for (int i = 0; i < `DMEM_DEPTH; i++)
			model_written[i] = 1'b0;
		for (int i = 0; i < `IMEM_DEPTH; i++)
			program_words[i] = `NOP_INSTR;
		for (int i = 0; i < NUM_INSTR; i++) begin
			kind = int'($urandom_range(9, 0));
			w = '0;
			w.dp.cond = 4'hE;
			if (kind < 6 && !(prev_store && kind < 3)) begin
				w.dp.cls = `CLASS_DP;
				w.dp.imm = 1'($urandom_range(1, 0));
				w.dp.opcode = pick_opcode();
				w.dp.rn = pick_reg();
				w.dp.rd = pick_reg();
				w.dp.operand2 = w.dp.imm ? {4'h0, 8'($urandom_range(255, 0))}
					: {8'h0, pick_reg()};
			end else if (kind < 9) begin
				w.mem.cls = `CLASS_MEM;
				w.mem.p = 1'b1;
				w.mem.u = 1'b1;
				w.mem.rd = pick_reg();
				if (prev_store) begin
					// read back the word just stored
					w.mem.load = 1'b1;
					w.mem.rn = prev_rn;
					w.mem.offset = prev_offset;
				end else begin
					w.mem.load = 1'($urandom_range(1, 0));
					w.mem.rn = pick_reg();
					w.mem.offset = 12'($urandom_range(4095, 0));
				end
				// data memory has no reset, loads only see written words
				addr = model_regs[w.mem.rn] + {{(`REGISTER_LEN-12){1'b0}}, w.mem.offset};
				if (!model_written[addr[DMEM_AW+1:2]])
					w.mem.load = 1'b0;
			end else if ($urandom_range(1, 0) == 0) begin
				w = `NOP_INSTR;
			end else begin
				// unknown data-processing opcode
				w.dp.cls = `CLASS_DP;
				w.dp.opcode = 4'b0011;
				w.dp.rn = pick_reg();
				w.dp.rd = pick_reg();
			end
			prev_store = (w.mem.cls == `CLASS_MEM) && !w.mem.load;
			prev_rn = w.mem.rn;
			prev_offset = w.mem.offset;
			program_words[i] = w;
			model_step(w);
		end
	endtask

	// ########################################################################
	// main sequence
	// ########################################################################

	initial begin
		void'($urandom(32'h7869));
		rst_n = 1'b0;
		imem_load_en = 1'b0;
		imem_load_addr = '0;
		imem_load_data = '0;
		build_program();
		for (int i = 0; i < `IMEM_DEPTH; i++) begin
			@(posedge clk);
			imem_load_en <= 1'b1;
			imem_load_addr <= IMEM_AW'(i);
			imem_load_data <= program_words[i];
		end
		@(posedge clk);
		imem_load_en <= 1'b0;
		for (int i = 0; i < RESET_CYCLES; i++) begin
			@(negedge clk);
			check_value("reset wb_en", 32'd0, 32'(wb.wb_en));
		end
		@(posedge clk);
		rst_n <= 1'b1;
		for (int i = 0; i < exp_dest.size(); i++) begin
			wait_retire(i);
			check_value($sformatf("retire %0d dest", i), 32'(exp_dest[i]), 32'(wb.dest));
			check_value($sformatf("retire %0d value", i), exp_value[i], wb.value);
		end
		// no-ops and unknown opcodes must not retire
		for (int i = 0; i < QUIET_CYCLES; i++) begin
			@(negedge clk);
			check_value("extra retire", 32'd0, 32'(wb.wb_en));
		end
		$display("Test completed successfully");
		$finish;
	end

endmodule

//--- verilog/arm_core.sv
`timescale 1ns/1ps
`include "arm_defs.svh"

module arm_core (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           imem_load_en,
	input  logic [$clog2(`IMEM_DEPTH)-1:0] imem_load_addr,
	input  logic [`INSTR_LEN-1:0]          imem_load_data,
	output arm_pkg::wb_t                   wb
);

	// ########################################################################
	// fetch and decode
	// ########################################################################

	logic                        stall;
	arm_pkg::instr_u             instr;
	logic [`REG_ADDRESS_LEN-1:0] src1, src2;
	logic                        use_src1, two_src;
	arm_pkg::id_ex_t             id_ex;

	if_stage u_if_stage (
		.clk(clk), .rst_n(rst_n), .stall(stall),
		.imem_load_en(imem_load_en),
		.imem_load_addr(imem_load_addr),
		.imem_load_data(imem_load_data),
		.instr(instr),
		.pc()
	);

	id_stage u_id_stage (
		.clk(clk), .rst_n(rst_n), .stall(stall),
		.instr(instr), .wb(wb),
		.src1(src1), .src2(src2),
		.use_src1(use_src1), .two_src(two_src),
		.id_ex(id_ex)
	);

	// ########################################################################
	// execute, memory and writeback
	// ########################################################################

	arm_pkg::ex_mem_t     ex_mem;
	arm_pkg::hazard_src_t exe_haz, mem_haz;

	ex_stage u_ex_stage (
		.clk(clk), .rst_n(rst_n),
		.id_ex(id_ex), .ex_mem(ex_mem), .hazard(exe_haz)
	);

	mem_stage u_mem_stage (
		.clk(clk), .rst_n(rst_n),
		.ex_mem(ex_mem), .wb(wb), .hazard(mem_haz)
	);

	hazard_unit u_hazard_unit (
		.src1(src1), .src2(src2),
		.use_src1(use_src1), .two_src(two_src),
		.exe(exe_haz), .mem(mem_haz),
		.stall(stall)
	);

endmodule

//--- verilog/ex_stage.sv
`timescale 1ns/1ps
`include "arm_defs.svh"

module ex_stage (
	input  logic                 clk,
	input  logic                 rst_n,
	input  arm_pkg::id_ex_t      id_ex,
	output arm_pkg::ex_mem_t     ex_mem,
	output arm_pkg::hazard_src_t hazard
);

	logic [`REGISTER_LEN-1:0] addr_sum;
	logic [`REGISTER_LEN-1:0] alu_out;

	// address adder, shared with ADD
	assign addr_sum = id_ex.val_rn + id_ex.val_op2;

	always_comb begin
		case (id_ex.alu_cmd)
			arm_pkg::alu_and:  alu_out = id_ex.val_rn & id_ex.val_op2;
			arm_pkg::alu_eor:  alu_out = id_ex.val_rn ^ id_ex.val_op2;
			arm_pkg::alu_sub:  alu_out = id_ex.val_rn - id_ex.val_op2;
			arm_pkg::alu_add:  alu_out = addr_sum;
			arm_pkg::alu_orr:  alu_out = id_ex.val_rn | id_ex.val_op2;
			arm_pkg::alu_mov:  alu_out = id_ex.val_op2;
			arm_pkg::alu_pass: alu_out = addr_sum;
			default:           alu_out = '0;
		endcase
	end

	// instruction now in EX
	assign hazard = '{wb_en: id_ex.valid && id_ex.wb_en, dest: id_ex.dest};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_mem <= '0;
		end else begin
			ex_mem.valid <= id_ex.valid;
			ex_mem.wb_en <= id_ex.wb_en;
			ex_mem.mem_read <= id_ex.mem_read;
			ex_mem.mem_write <= id_ex.mem_write;
			ex_mem.alu_res <= alu_out;
			ex_mem.val_rm <= id_ex.val_rm;
			ex_mem.dest <= id_ex.dest;
		end
	end

	a_rw_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(id_ex.mem_read && id_ex.mem_write))
		else $error("decode issued a load and a store together");

endmodule

//--- verilog/hazard_unit.sv
`timescale 1ns/1ps
`include "arm_defs.svh"

module hazard_unit (
	input  logic [`REG_ADDRESS_LEN-1:0] src1,
	input  logic [`REG_ADDRESS_LEN-1:0] src2,
	input  logic                        use_src1,
	input  logic                        two_src,
	input  arm_pkg::hazard_src_t        exe,
	input  arm_pkg::hazard_src_t        mem,
	output logic                        stall
);

	logic src1_hit, src2_hit;

	function automatic logic writes_to(
		input logic [`REG_ADDRESS_LEN-1:0] idx,
		input arm_pkg::hazard_src_t        h
	);
		return h.wb_en && (h.dest == idx);
	endfunction

	// WB stage is covered by the write-first register file
	assign src1_hit = use_src1 && (writes_to(src1, exe) || writes_to(src1, mem));
	assign src2_hit = two_src && (writes_to(src2, exe) || writes_to(src2, mem));

	assign stall = src1_hit || src2_hit;

endmodule

//--- verilog/id_stage.sv
`timescale 1ns/1ps
`include "arm_defs.svh"

module id_stage (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        stall,
	input  arm_pkg::instr_u             instr,
	input  arm_pkg::wb_t                wb,
	output logic [`REG_ADDRESS_LEN-1:0] src1,
	output logic [`REG_ADDRESS_LEN-1:0] src2,
	output logic                        use_src1,
	output logic                        two_src,
	output arm_pkg::id_ex_t             id_ex
);

	localparam int NUM_REGS = 1 << `REG_ADDRESS_LEN;

	logic [`REGISTER_LEN-1:0] regs [0:NUM_REGS-1];
	logic [`REGISTER_LEN-1:0] rn_val, rm_val, rd_val;
	arm_pkg::id_ex_t          dec;
	logic                     dec_ok;

	// write-first read port
	function automatic logic [`REGISTER_LEN-1:0] read_port(
		input arm_pkg::wb_t                w,
		input logic [`REG_ADDRESS_LEN-1:0] idx,
		input logic [`REGISTER_LEN-1:0]    stored
	);
		return (w.wb_en && w.dest == idx) ? w.value : stored;
	endfunction

	assign rn_val = read_port(wb, instr.dp.rn, regs[instr.dp.rn]);
	assign rm_val = read_port(wb, instr.dp.operand2[3:0], regs[instr.dp.operand2[3:0]]);
	assign rd_val = read_port(wb, instr.dp.rd, regs[instr.dp.rd]);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wb.wb_en) begin
			regs[wb.dest] <= wb.value;
		end
	end

	// ########################################################################
	// decode
	// ########################################################################

	always_comb begin
		dec = '0;
		dec_ok = 1'b0;
		use_src1 = 1'b0;
		two_src = 1'b0;
		src1 = instr.dp.rn;
		src2 = instr.dp.operand2[3:0];
		case (instr.dp.cls)
			`CLASS_DP: begin
				dec_ok = 1'b1;
				case (instr.dp.opcode)
					`OP_AND: dec.alu_cmd = arm_pkg::alu_and;
					`OP_EOR: dec.alu_cmd = arm_pkg::alu_eor;
					`OP_SUB: dec.alu_cmd = arm_pkg::alu_sub;
					`OP_ADD: dec.alu_cmd = arm_pkg::alu_add;
					`OP_ORR: dec.alu_cmd = arm_pkg::alu_orr;
					`OP_MOV: dec.alu_cmd = arm_pkg::alu_mov;
					default: dec_ok = 1'b0;
				endcase
				// MOV ignores rn
				use_src1 = dec_ok && (instr.dp.opcode != `OP_MOV);
				two_src = dec_ok && !instr.dp.imm;
				dec.val_op2 = instr.dp.imm ?
					{{(`REGISTER_LEN-8){1'b0}}, instr.dp.operand2[7:0]} : rm_val;
				dec.wb_en = 1'b1;
				dec.dest = instr.dp.rd;
			end
			`CLASS_MEM: begin
				dec_ok = 1'b1;
				use_src1 = 1'b1;
				// store data comes from rd
				two_src = !instr.mem.load;
				src2 = instr.mem.rd;
				dec.alu_cmd = arm_pkg::alu_pass;
				dec.val_op2 = {{(`REGISTER_LEN-12){1'b0}}, instr.mem.offset};
				dec.mem_read = instr.mem.load;
				dec.mem_write = !instr.mem.load;
				dec.wb_en = instr.mem.load;
				dec.dest = instr.mem.rd;
			end
			default: ;
		endcase
		dec.valid = dec_ok;
		dec.val_rn = rn_val;
		dec.val_rm = rd_val;
	end

	// stalls and no-ops both leave a bubble in ID/EX
	always_ff @(posedge clk) begin
		if (!rst_n)
			id_ex <= '0;
		else if (stall || !dec_ok)
			id_ex <= '0;
		else
			id_ex <= dec;
	end

endmodule

//--- verilog/if_stage.sv
`timescale 1ns/1ps
`include "arm_defs.svh"

module if_stage (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            stall,
	input  logic                            imem_load_en,
	input  logic [$clog2(`IMEM_DEPTH)-1:0]  imem_load_addr,
	input  logic [`INSTR_LEN-1:0]           imem_load_data,
	output arm_pkg::instr_u                 instr,
	output logic [`ADDRESS_LEN-1:0]         pc
);

	localparam int IMEM_AW = $clog2(`IMEM_DEPTH);

	logic [`INSTR_LEN-1:0]   imem [0:`IMEM_DEPTH-1];
	logic [`ADDRESS_LEN-1:0] pc_inc;

	// program is written in only while the core sits in reset
	always_ff @(posedge clk) begin
		if (!rst_n && imem_load_en)
			imem[imem_load_addr] <= imem_load_data;
	end

	// byte pc, wraps at the end of instruction memory
	assign pc_inc = pc + 4;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= '0;
			instr <= `NOP_INSTR;
		end else if (!stall) begin
			pc <= {{(`ADDRESS_LEN-IMEM_AW-2){1'b0}}, pc_inc[IMEM_AW+1:0]};
			instr <= imem[pc[IMEM_AW+1:2]];
		end
	end

	a_load_in_reset: assert property (@(posedge clk) imem_load_en |-> !rst_n)
		else $error("instruction memory written while core is running");

endmodule

//--- verilog/mem_stage.sv
`timescale 1ns/1ps
`include "arm_defs.svh"

module mem_stage (
	input  logic                 clk,
	input  logic                 rst_n,
	input  arm_pkg::ex_mem_t     ex_mem,
	output arm_pkg::wb_t         wb,
	output arm_pkg::hazard_src_t hazard
);

	localparam int DMEM_AW = $clog2(`DMEM_DEPTH);

	logic [`REGISTER_LEN-1:0] dmem [0:`DMEM_DEPTH-1];
	logic [DMEM_AW-1:0]       word_idx;

	// word address, wraps over the data memory
	assign word_idx = ex_mem.alu_res[DMEM_AW+1:2];

	always_ff @(posedge clk) begin
		if (ex_mem.valid && ex_mem.mem_write)
			dmem[word_idx] <= ex_mem.val_rm;
	end

	// instruction now in MEM
	assign hazard = '{wb_en: ex_mem.valid && ex_mem.wb_en, dest: ex_mem.dest};

	// ########################################################################
	// writeback select
	// ########################################################################

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb <= '0;
		end else begin
			wb.wb_en <= ex_mem.valid && ex_mem.wb_en;
			wb.dest <= ex_mem.dest;
			wb.value <= ex_mem.mem_read ? dmem[word_idx] : ex_mem.alu_res;
		end
	end

endmodule
